/* hdl/slam_pkg.sv */
`default_nettype none

package slam_pkg;

  // q16.16 word
  localparam int DATA_W = 32;
  typedef logic signed [DATA_W-1:0] data_t;

  // defaults, the top level passes these down as parameters
  localparam int DIM_DEF        = 3;
  localparam int FRAC_BITS_DEF  = 16;
  localparam int CREDIT_MAX_DEF = 4;

  // entry index: P row-major first, then x, y, theta
  localparam int ENTRY_W = 4;

  // stage commands from the host
  typedef enum logic [1:0] {
    STG_IDLE    = 2'd0,
    STG_PREDICT = 2'd1,
    STG_READOUT = 2'd2
  } stage_cmd_e;

  // stage request, 3 bits
  typedef struct packed {
    logic       valid;
    stage_cmd_e cmd;
  } stage_req_t;

  // host write into the bank, 37 bits
  typedef struct packed {
    logic               valid;
    logic [ENTRY_W-1:0] idx;
    data_t              data;
  } entry_wr_t;

  // readout word on S, 33 bits
  typedef struct packed {
    logic  valid;
    data_t data;
  } stream_t;

  // state out to the nonlinear unit, 97 bits
  typedef struct packed {
    logic  init;
    data_t xk;
    data_t yk;
    data_t xita;
  } nl_req_t;

  // results back from the nonlinear unit, 97 bits
  typedef struct packed {
    logic  done;
    data_t result_1;
    data_t result_2;
    data_t result_3;
  } nl_rsp_t;

endpackage

`default_nettype wire

/* hdl/pe_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_mac #(
  parameter int FRAC_BITS = slam_pkg::FRAC_BITS_DEF
) (
  input  wire             clk,
  input  wire             sys_rst,
  input  slam_pkg::data_t i_a,
  input  slam_pkg::data_t i_b,
  input  slam_pkg::data_t i_m,
  input  wire             i_fire,
  output slam_pkg::data_t o_a,
  output slam_pkg::data_t o_b,
  output slam_pkg::data_t o_c
);

  import slam_pkg::*;

  // full signed product, then drop the fraction
  logic signed [2*DATA_W-1:0] prod_full;
  logic signed [2*DATA_W-1:0] prod_shr;
  data_t                      prod_q;

  assign prod_full = i_a * i_b;
  assign prod_shr  = prod_full >>> FRAC_BITS;
  // low word only, sums wrap
  assign prod_q    = data_t'(prod_shr[DATA_W-1:0]);

  // a goes east, b goes north, one cycle per hop
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // result only moves when the fire token reaches this PE
  always_ff @(posedge clk) begin
    if (i_fire) begin
      o_c <= i_m + prod_q;
    end
  end

endmodule

`default_nettype wire

/* hdl/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_array #(
  parameter int DIM       = slam_pkg::DIM_DEF,
  parameter int FRAC_BITS = slam_pkg::FRAC_BITS_DEF
) (
  input  wire             clk,
  input  wire             sys_rst,
  input  wire             i_start,
  input  slam_pkg::data_t i_a_col [DIM],
  input  slam_pkg::data_t i_b_row [DIM],
  input  slam_pkg::data_t i_m_blk [DIM][DIM],
  output slam_pkg::data_t o_c_blk [DIM][DIM],
  output logic            o_done
);

  import slam_pkg::*;

  // skewed lane heads into column 0 and row 0
  data_t a_sk [DIM];
  data_t b_sk [DIM];
  // east and north hops between PEs
  data_t a_e [DIM][DIM];
  data_t b_n [DIM][DIM];
  // tok_q[d] is high d cycles after start
  logic [2*DIM-2:1] tok_q;

  // lane k runs k cycles late for both a and b
  for (genvar k = 0; k < DIM; k++) begin : g_lane
    if (k == 0) begin : g_direct
      assign a_sk[k] = i_a_col[k];
      assign b_sk[k] = i_b_row[k];
    end else begin : g_dly
      data_t a_chain [1:k];
      data_t b_chain [1:k];

      always_ff @(posedge clk) begin
        a_chain[1] <= i_a_col[k];
        b_chain[1] <= i_b_row[k];
        for (int n = 2; n <= k; n++) begin
          a_chain[n] <= a_chain[n-1];
          b_chain[n] <= b_chain[n-1];
        end
      end

      assign a_sk[k] = a_chain[k];
      assign b_sk[k] = b_chain[k];
    end
  end

  // token walks the anti-diagonals
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      tok_q  <= '0;
      o_done <= 1'b0;
    end else begin
      tok_q  <= {tok_q[2*DIM-3:1], i_start};
      // last PE fired the cycle before
      o_done <= tok_q[2*DIM-2];
    end
  end

  for (genvar i = 0; i < DIM; i++) begin : g_row
    for (genvar j = 0; j < DIM; j++) begin : g_col
      data_t a_in;
      data_t b_in;
      logic  fire;

      if (j == 0) begin : g_a_edge
        assign a_in = a_sk[i];
      end else begin : g_a_hop
        assign a_in = a_e[i][j-1];
      end

      if (i == 0) begin : g_b_edge
        assign b_in = b_sk[j];
      end else begin : g_b_hop
        assign b_in = b_n[i-1][j];
      end

      // PE(i,j) fires i+j cycles after start
      if (i + j == 0) begin : g_fire0
        assign fire = i_start;
      end else begin : g_fire
        assign fire = tok_q[i+j];
      end

      pe_mac #(
        .FRAC_BITS (FRAC_BITS)
      ) u_pe (
        .clk     (clk),
        .sys_rst (sys_rst),
        .i_a     (a_in),
        .i_b     (b_in),
        .i_m     (i_m_blk[i][j]),
        .i_fire  (fire),
        .o_a     (a_e[i][j]),
        .o_b     (b_n[i][j]),
        .o_c     (o_c_blk[i][j])
      );
    end
  end

  // the bank writes the whole block on a single done strobe
  a_done_pulse: assert property (@(posedge clk) disable iff (sys_rst)
    o_done |=> !o_done);

endmodule

`default_nettype wire

/* hdl/predict_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module predict_capture #(
  parameter int DIM = slam_pkg::DIM_DEF
) (
  input  wire               clk,
  input  wire               sys_rst,
  input  slam_pkg::nl_rsp_t i_nl_rsp,
  input  slam_pkg::data_t   i_state     [3],
  output slam_pkg::data_t   o_state_new [3],
  output slam_pkg::data_t   o_a_col     [DIM]
);

  import slam_pkg::*;

  // state order is x, y, theta
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int s = 0; s < 3; s++) begin
        o_state_new[s] <= '0;
      end
      for (int k = 0; k < DIM; k++) begin
        o_a_col[k] <= '0;
      end
    end else if (i_nl_rsp.done) begin
      // motion increments from the nonlinear unit
      o_state_new[0] <= i_state[0] + i_nl_rsp.result_2;
      o_state_new[1] <= i_state[1] + i_nl_rsp.result_3;
      o_state_new[2] <= i_state[2] + i_nl_rsp.result_1;
      // jacobian column against theta
      for (int k = 0; k < DIM; k++) begin
        if (k == 0) begin
          o_a_col[k] <= -i_nl_rsp.result_3;
        end else if (k == 1) begin
          o_a_col[k] <= i_nl_rsp.result_2;
        end else begin
          // a zero entry leaves that row of P unchanged
          o_a_col[k] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/cov_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module cov_bank #(
  parameter int DIM = slam_pkg::DIM_DEF
) (
  input  wire                           clk,
  input  wire                           sys_rst,
  input  wire                           i_host_en,
  input  slam_pkg::entry_wr_t           i_wr,
  input  wire                           i_blk_we,
  input  slam_pkg::data_t               i_c_blk     [DIM][DIM],
  input  wire                           i_state_we,
  input  slam_pkg::data_t               i_state_new [3],
  input  wire [slam_pkg::ENTRY_W-1:0]   i_rd_idx,
  output slam_pkg::data_t               o_rd_data,
  output slam_pkg::data_t               o_p_blk     [DIM][DIM],
  output slam_pkg::data_t               o_b_row     [DIM],
  output slam_pkg::data_t               o_state     [3]
);

  import slam_pkg::*;

  localparam int NP = DIM * DIM;

  // covariance block and robot pose
  data_t p_q  [DIM][DIM];
  data_t st_q [3];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int r = 0; r < DIM; r++) begin
        for (int c = 0; c < DIM; c++) begin
          p_q[r][c] <= '0;
        end
      end
      for (int s = 0; s < 3; s++) begin
        st_q[s] <= '0;
      end
    end else begin
      // whole block from the array on its done strobe
      if (i_blk_we) begin
        p_q <= i_c_blk;
      end
      // new pose one cycle later
      if (i_state_we) begin
        st_q <= i_state_new;
      end
      // host port, only open while the controller is idle
      if (i_host_en && i_wr.valid) begin
        for (int r = 0; r < DIM; r++) begin
          for (int c = 0; c < DIM; c++) begin
            if (i_wr.idx == ENTRY_W'(r*DIM + c)) begin
              p_q[r][c] <= i_wr.data;
            end
          end
        end
        for (int s = 0; s < 3; s++) begin
          if (i_wr.idx == ENTRY_W'(NP + s)) begin
            st_q[s] <= i_wr.data;
          end
        end
      end
    end
  end

  // combinational read by entry index
  always_comb begin
    o_rd_data = '0;
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        if (i_rd_idx == ENTRY_W'(r*DIM + c)) begin
          o_rd_data = p_q[r][c];
        end
      end
    end
    for (int s = 0; s < 3; s++) begin
      if (i_rd_idx == ENTRY_W'(NP + s)) begin
        o_rd_data = st_q[s];
      end
    end
  end

  assign o_p_blk = p_q;
  // last row is the one F touches
  assign o_b_row = p_q[DIM-1];
  assign o_state = st_q;

  // host must not write while a stage is running
  a_host_idle: assert property (@(posedge clk) disable iff (sys_rst)
    i_wr.valid |-> i_host_en);

endmodule

`default_nettype wire

/* hdl/stage_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl #(
  parameter int DIM        = slam_pkg::DIM_DEF,
  parameter int CREDIT_MAX = slam_pkg::CREDIT_MAX_DEF
) (
  input  wire                               clk,
  input  wire                               sys_rst,
  input  slam_pkg::stage_req_t              i_stage_req,
  output logic                              o_stage_rdy,
  output logic                              o_nl_init,
  input  wire                               i_nl_done,
  output logic                              o_arr_start,
  input  wire                               i_arr_done,
  output logic                              o_blk_we,
  output logic                              o_state_we,
  output logic                              o_host_en,
  output logic [slam_pkg::ENTRY_W-1:0]      o_rd_idx,
  input  slam_pkg::data_t                   i_rd_data,
  input  wire                               i_s_credit,
  output slam_pkg::stream_t                 o_s
);

  import slam_pkg::*;

  // theta is the last entry after P, x and y
  localparam int LAST_IDX = DIM*DIM + 2;
  localparam int CRED_W   = $clog2(CREDIT_MAX + 1);

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_NL_WAIT = 3'd1,
    ST_ARRAY   = 3'd2,
    ST_COMMIT  = 3'd3,
    ST_STREAM  = 3'd4
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic                accept;
  logic                send;
  logic                last_word;
  logic [ENTRY_W-1:0]  idx_q;
  logic [CRED_W-1:0]   credit_q;

  // ready and host writes only in idle
  assign o_stage_rdy = (state_q == ST_IDLE);
  assign o_host_en   = (state_q == ST_IDLE);
  assign accept      = i_stage_req.valid && o_stage_rdy;

  // one word per cycle while credits remain
  assign send      = (state_q == ST_STREAM) && (credit_q != '0);
  assign last_word = send && (idx_q == ENTRY_W'(LAST_IDX));

  // bank writes ride on the array strobe and the commit state
  assign o_blk_we   = (state_q == ST_ARRAY) && i_arr_done;
  assign o_state_we = (state_q == ST_COMMIT);

  assign o_rd_idx   = idx_q;
  assign o_s.valid  = send;
  assign o_s.data   = i_rd_data;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          if (i_stage_req.cmd == STG_PREDICT) begin
            state_d = ST_NL_WAIT;
          end else if (i_stage_req.cmd == STG_READOUT) begin
            state_d = ST_STREAM;
          end
        end
      end
      // nonlinear latency is open-ended
      ST_NL_WAIT: begin
        if (i_nl_done) begin
          state_d = ST_ARRAY;
        end
      end
      ST_ARRAY: begin
        if (i_arr_done) begin
          state_d = ST_COMMIT;
        end
      end
      ST_COMMIT: begin
        state_d = ST_IDLE;
      end
      ST_STREAM: begin
        if (last_word) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q     <= ST_IDLE;
      o_nl_init   <= 1'b0;
      o_arr_start <= 1'b0;
      idx_q       <= '0;
      credit_q    <= CRED_W'(CREDIT_MAX);
    end else begin
      state_q     <= state_d;
      // init one cycle after a predict is taken
      o_nl_init   <= accept && (i_stage_req.cmd == STG_PREDICT);
      // array starts the cycle after capture
      o_arr_start <= (state_q == ST_NL_WAIT) && i_nl_done;

      if (accept) begin
        idx_q <= '0;
      end else if (send) begin
        idx_q <= idx_q + 1'b1;
      end

      // credit return and spend in the same cycle cancel out
      case ({send, i_s_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // the receiver never returns more credits than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (sys_rst)
    credit_q <= CRED_W'(CREDIT_MAX));

  // a request offered while busy stays pending until idle takes it
  a_req_wait: assert property (@(posedge clk) disable iff (sys_rst)
    (i_stage_req.valid && !o_stage_rdy) |=>
      (i_stage_req.valid && $stable(i_stage_req.cmd)));

endmodule

`default_nettype wire

/* hdl/slam_rsa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module slam_rsa_top #(
  parameter int DIM        = slam_pkg::DIM_DEF,
  parameter int FRAC_BITS  = slam_pkg::FRAC_BITS_DEF,
  parameter int CREDIT_MAX = slam_pkg::CREDIT_MAX_DEF
) (
  input  wire                  clk,
  input  wire                  sys_rst,
  input  slam_pkg::stage_req_t i_stage_req,
  output logic                 o_stage_rdy,
  input  slam_pkg::entry_wr_t  i_wr,
  output slam_pkg::nl_req_t    o_nl_req,
  input  slam_pkg::nl_rsp_t    i_nl_rsp,
  output slam_pkg::stream_t    o_s,
  input  wire                  i_s_credit
);

  import slam_pkg::*;

  // controller strobes
  logic               nl_init;
  logic               arr_start;
  logic               arr_done;
  logic               blk_we;
  logic               state_we;
  logic               host_en;
  logic [ENTRY_W-1:0] rd_idx;
  data_t              rd_data;

  // datapath buses
  data_t state_cur [3];
  data_t state_new [3];
  data_t a_col     [DIM];
  data_t b_row     [DIM];
  data_t p_blk     [DIM][DIM];
  data_t c_blk     [DIM][DIM];

  // pose to the nonlinear unit is always the bank's copy
  assign o_nl_req.init = nl_init;
  assign o_nl_req.xk   = state_cur[0];
  assign o_nl_req.yk   = state_cur[1];
  assign o_nl_req.xita = state_cur[2];

  stage_ctrl #(
    .DIM        (DIM),
    .CREDIT_MAX (CREDIT_MAX)
  ) u_stage_ctrl (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_stage_req (i_stage_req),
    .o_stage_rdy (o_stage_rdy),
    .o_nl_init   (nl_init),
    .i_nl_done   (i_nl_rsp.done),
    .o_arr_start (arr_start),
    .i_arr_done  (arr_done),
    .o_blk_we    (blk_we),
    .o_state_we  (state_we),
    .o_host_en   (host_en),
    .o_rd_idx    (rd_idx),
    .i_rd_data   (rd_data),
    .i_s_credit  (i_s_credit),
    .o_s         (o_s)
  );

  predict_capture #(
    .DIM (DIM)
  ) u_predict_capture (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_nl_rsp    (i_nl_rsp),
    .i_state     (state_cur),
    .o_state_new (state_new),
    .o_a_col     (a_col)
  );

  pe_array #(
    .DIM       (DIM),
    .FRAC_BITS (FRAC_BITS)
  ) u_pe_array (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_start (arr_start),
    .i_a_col (a_col),
    .i_b_row (b_row),
    .i_m_blk (p_blk),
    .o_c_blk (c_blk),
    .o_done  (arr_done)
  );

  cov_bank #(
    .DIM (DIM)
  ) u_cov_bank (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_host_en   (host_en),
    .i_wr        (i_wr),
    .i_blk_we    (blk_we),
    .i_c_blk     (c_blk),
    .i_state_we  (state_we),
    .i_state_new (state_new),
    .i_rd_idx    (rd_idx),
    .o_rd_data   (rd_data),
    .o_p_blk     (p_blk),
    .o_b_row     (b_row),
    .o_state     (state_cur)
  );

endmodule

`default_nettype wire

/* testbench/tb_slam_rsa.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_slam_rsa;

  import slam_pkg::*;

  localparam int DIM        = DIM_DEF;
  localparam int FRAC_BITS  = FRAC_BITS_DEF;
  localparam int CREDIT_MAX = CREDIT_MAX_DEF;
  localparam int NP         = DIM * DIM;
  // P row-major followed by x, y and theta
  localparam int NWORDS     = NP + 3;
  localparam int N_ROWS     = 5;
  localparam int RST_CYC    = 10;
  localparam int MAX_HOLD   = 16;
  localparam int MAX_NL_DLY = 8;
  // worst case per row is a load, two predicts and a stalled readout
  localparam int PRED_CYC    = 4 + MAX_NL_DLY + 2*DIM + 4;
  localparam int READ_CYC    = MAX_HOLD + 2*NWORDS + CREDIT_MAX + 8;
  localparam int ROW_CYC     = NWORDS + 4 + 2*PRED_CYC + READ_CYC;
  localparam int CYCLE_LIMIT = RST_CYC + N_ROWS*ROW_CYC + 20;

  // results b only feed the second predict
  typedef struct packed {
    logic       chk_rst;
    logic       do_load;
    logic [1:0] n_pred;
    logic [7:0] hold;
    data_t      r1_a;
    data_t      r2_a;
    data_t      r3_a;
    data_t      r1_b;
    data_t      r2_b;
    data_t      r3_b;
  } row_t;

  logic       clk;
  logic       sys_rst;
  stage_req_t stage_req;
  logic       stage_rdy;
  entry_wr_t  wr;
  nl_req_t    nl_req;
  nl_rsp_t    nl_rsp;
  stream_t    s_out;
  logic       s_credit;

  row_t  rows     [N_ROWS];
  string names    [N_ROWS];
  // reference copy of the bank
  data_t model_p  [NP];
  data_t model_st [3];
  int    test_errs;
  int    total_errs;
  int    n_ok;
  int    cycle_cnt = 0;

  slam_rsa_top #(
    .DIM        (DIM),
    .FRAC_BITS  (FRAC_BITS),
    .CREDIT_MAX (CREDIT_MAX)
  ) dut_i (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_stage_req (stage_req),
    .o_stage_rdy (stage_rdy),
    .i_wr        (wr),
    .o_nl_req    (nl_req),
    .i_nl_rsp    (nl_rsp),
    .o_s         (s_out),
    .i_s_credit  (s_credit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run length guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  function automatic row_t make_row(logic chk, logic ld, int np, int hold,
                                    data_t r1a, data_t r2a, data_t r3a,
                                    data_t r1b, data_t r2b, data_t r3b);
    row_t r;
    r.chk_rst = chk;
    r.do_load = ld;
    r.n_pred  = 2'(np);
    r.hold    = 8'(hold);
    r.r1_a    = r1a;
    r.r2_a    = r2a;
    r.r3_a    = r3a;
    r.r1_b    = r1b;
    r.r2_b    = r2b;
    r.r3_b    = r3b;
    return r;
  endfunction

  // q16.16 product shifted arithmetically with the low word kept
  function automatic data_t q_mul(data_t a, data_t b);
    logic signed [2*DATA_W-1:0] full;
    logic signed [2*DATA_W-1:0] shr;
    full = a * b;
    shr  = full >>> FRAC_BITS;
    return shr[DATA_W-1:0];
  endfunction

  function automatic data_t expected_word(int idx);
    if (idx < NP) begin
      return model_p[idx];
    end
    return model_st[idx-NP];
  endfunction

  // P' = P + a * (last row of P) and the pose adds the increments
  task automatic update_model(data_t r1, data_t r2, data_t r3);
    data_t a_col    [DIM];
    data_t last_row [DIM];
    for (int k = 0; k < DIM; k++) begin
      a_col[k]    = '0;
      last_row[k] = model_p[(DIM-1)*DIM + k];
    end
    a_col[0] = -r3;
    a_col[1] = r2;
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        model_p[i*DIM + j] = model_p[i*DIM + j] + q_mul(a_col[i], last_row[j]);
      end
    end
    model_st[0] = model_st[0] + r2;
    model_st[1] = model_st[1] + r3;
    model_st[2] = model_st[2] + r1;
  endtask

  // every entry gets a fresh random word
  task automatic load_random();
    data_t val;
    for (int k = 0; k < NWORDS; k++) begin
      val = data_t'($urandom);
      @(posedge clk);
      #1;
      wr.valid = 1'b1;
      wr.idx   = ENTRY_W'(k);
      wr.data  = val;
      if (k < NP) begin
        model_p[k] = val;
      end else begin
        model_st[k-NP] = val;
      end
    end
    @(posedge clk);
    #1;
    wr = '0;
  endtask

  // hold the request until valid and rdy meet at an edge
  task automatic request_stage(stage_cmd_e cmd);
    logic taken;
    taken = 1'b0;
    @(posedge clk);
    #1;
    stage_req.valid = 1'b1;
    stage_req.cmd   = cmd;
    while (!taken) begin
      @(negedge clk);
      taken = stage_rdy;
      @(posedge clk);
      #1;
    end
    stage_req = '0;
  endtask

  task automatic run_predict(data_t r1, data_t r2, data_t r3);
    int dly;
    request_stage(STG_PREDICT);
    // pose in the init cycle is still the old one
    @(negedge clk);
    if (stage_rdy !== 1'b0) begin
      $display("FAILED o_stage_rdy expected %h got %h", 1'b0, stage_rdy);
      test_errs++;
    end
    if (nl_req.init !== 1'b1) begin
      $display("FAILED o_nl_req.init expected %h got %h", 1'b1, nl_req.init);
      test_errs++;
    end
    if (nl_req.xk !== model_st[0]) begin
      $display("FAILED o_nl_req.xk expected %h got %h", model_st[0], nl_req.xk);
      test_errs++;
    end
    if (nl_req.yk !== model_st[1]) begin
      $display("FAILED o_nl_req.yk expected %h got %h", model_st[1], nl_req.yk);
      test_errs++;
    end
    if (nl_req.xita !== model_st[2]) begin
      $display("FAILED o_nl_req.xita expected %h got %h", model_st[2], nl_req.xita);
      test_errs++;
    end
    // nonlinear unit answers after a random delay
    dly = 1 + int'($urandom % MAX_NL_DLY);
    repeat (dly) @(posedge clk);
    #1;
    nl_rsp.done     = 1'b1;
    nl_rsp.result_1 = r1;
    nl_rsp.result_2 = r2;
    nl_rsp.result_3 = r3;
    @(posedge clk);
    #1;
    nl_rsp = '0;
    // end of predict is rdy coming back, init stays a single pulse
    do begin
      @(negedge clk);
      if (nl_req.init !== 1'b0) begin
        $display("FAILED o_nl_req.init expected %h got %h", 1'b0, nl_req.init);
        test_errs++;
      end
    end while (!stage_rdy);
    update_model(r1, r2, r3);
  endtask

  // credits held back for hold cycles and then returned one per word
  task automatic run_readout(int hold);
    int    n_got;
    int    owed;
    int    cyc;
    logic  returned;
    data_t exp_w;
    n_got    = 0;
    owed     = 0;
    cyc      = 0;
    returned = 1'b0;
    request_stage(STG_READOUT);
    while (n_got < NWORDS || owed > 0) begin
      @(negedge clk);
      if (cyc == 0 && stage_rdy !== 1'b0) begin
        $display("FAILED o_stage_rdy expected %h got %h", 1'b0, stage_rdy);
        test_errs++;
      end
      if (s_out.valid) begin
        if (n_got >= NWORDS) begin
          $display("stream sent a word after the last entry");
          test_errs++;
        end else begin
          exp_w = expected_word(n_got);
          if (s_out.data !== exp_w) begin
            $display("FAILED o_s.data[%0d] expected %h got %h", n_got, exp_w, s_out.data);
            test_errs++;
          end
        end
        n_got++;
        owed++;
        if (!returned && n_got > CREDIT_MAX) begin
          $display("stream sent %0d words with only %0d credits", n_got, CREDIT_MAX);
          test_errs++;
        end
      end
      @(posedge clk);
      #1;
      cyc++;
      if (owed > 0 && cyc > hold) begin
        s_credit = 1'b1;
        owed--;
        returned = 1'b1;
      end else begin
        s_credit = 1'b0;
      end
    end
    // last credit pulse is counted at this edge
    @(posedge clk);
    #1;
    s_credit = 1'b0;
    @(negedge clk);
    if (!stage_rdy) begin
      $display("readout did not return the controller to idle");
      test_errs++;
    end
  endtask

  initial begin
    void'($urandom(91365));
    sys_rst    = 1'b1;
    stage_req  = '0;
    wr         = '0;
    nl_rsp     = '0;
    s_credit   = 1'b0;
    total_errs = 0;
    n_ok       = 0;
    for (int k = 0; k < NP; k++) begin
      model_p[k] = '0;
    end
    for (int s = 0; s < 3; s++) begin
      model_st[s] = '0;
    end

    // columns are chk, load, predicts, credit hold and q16.16 results a then b
    names[0] = "reset state";
    rows[0]  = make_row(1'b1, 1'b0, 0, 0, '0, '0, '0, '0, '0, '0);
    names[1] = "load and readout";
    rows[1]  = make_row(1'b0, 1'b1, 0, 0, '0, '0, '0, '0, '0, '0);
    names[2] = "predict";
    rows[2]  = make_row(1'b0, 1'b1, 1, 0,
                        32'h0000_1000, 32'h0001_8000, 32'hFFFF_4000, '0, '0, '0);
    names[3] = "repeated predicts";
    rows[3]  = make_row(1'b0, 1'b1, 2, 0,
                        32'hFFFF_F000, 32'h0000_4000, 32'h0002_0000,
                        32'h0000_0800, 32'hFFFE_C000, 32'h0000_C000);
    names[4] = "credit back-pressure";
    rows[4]  = make_row(1'b0, 1'b0, 0, 12, '0, '0, '0, '0, '0, '0);

    repeat (RST_CYC) @(posedge clk);
    #1;
    sys_rst = 1'b0;

    for (int t = 0; t < N_ROWS; t++) begin
      test_errs = 0;
      if (rows[t].chk_rst) begin
        @(negedge clk);
        if (stage_rdy !== 1'b1) begin
          $display("FAILED o_stage_rdy expected %h got %h", 1'b1, stage_rdy);
          test_errs++;
        end
        if (s_out.valid !== 1'b0) begin
          $display("FAILED o_s.valid expected %h got %h", 1'b0, s_out.valid);
          test_errs++;
        end
        if (nl_req.init !== 1'b0) begin
          $display("FAILED o_nl_req.init expected %h got %h", 1'b0, nl_req.init);
          test_errs++;
        end
      end
      if (rows[t].do_load) begin
        load_random();
      end
      if (rows[t].n_pred >= 2'd1) begin
        run_predict(rows[t].r1_a, rows[t].r2_a, rows[t].r3_a);
      end
      if (rows[t].n_pred == 2'd2) begin
        run_predict(rows[t].r1_b, rows[t].r2_b, rows[t].r3_b);
      end
      run_readout(int'(rows[t].hold));
      if (test_errs == 0) begin
        n_ok++;
        $display("test %0d %s: ok", t + 1, names[t]);
      end else begin
        $display("test %0d %s: %0d errors", t + 1, names[t], test_errs);
      end
      total_errs += test_errs;
    end

    $display("%0d of %0d tests clean, %0d errors in total", n_ok, N_ROWS, total_errs);
    if (total_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hdl/slam_pkg.sv
hdl/pe_mac.sv
hdl/pe_array.sv
hdl/predict_capture.sv
hdl/cov_bank.sv
hdl/stage_ctrl.sv
hdl/slam_rsa_top.sv
testbench/tb_slam_rsa.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_slam_rsa
FILELIST   := project.f
OBJ_DIR    := obj_dir
PASS_MSG   := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
